// File: source/la_pkg.sv
`default_nettype none

package la_pkg;

    localparam int FRAME_BYTES = 6;          // mask lo/hi, pol lo/hi, prescale, post

    // byte positions inside a command frame
    localparam int FRM_MASK_LO = 0;
    localparam int FRM_MASK_HI = 1;
    localparam int FRM_POL_LO  = 2;
    localparam int FRM_POL_HI  = 3;
    localparam int FRM_PRESC   = 4;
    localparam int FRM_POST    = 5;

    typedef logic [7:0]  byte_t;             // channel byte, frame byte, ram read byte
    typedef logic [15:0] sample_t;           // probe sample, buffer word, mask, polarity

    typedef enum logic [1:0] {
        RECV,                                // collecting frame bytes
        ARM,                                 // single cycle, issues start
        CAPTURE,                             // sampler busy
        DUMP                                 // dump engine busy
    } cmd_state_e;

    typedef enum logic [1:0] {
        IDLE,                                // waiting for dump_start
        LOAD,                                // pick next byte, wait on ram if needed
        REQ,                                 // req high until ack rises
        REL                                  // req low until ack falls
    } dump_state_e;

endpackage

`default_nettype wire

// File: source/sample_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sample_ram #(
    parameter int ADDR_W = 8
) (
    input  wire              pll_clk,
    input  wire              we_i,
    input  wire [ADDR_W-1:0] waddr_i,
    input  la_pkg::sample_t  wdata_i,
    input  wire [ADDR_W:0]   raddr_i,                 // byte address, bit 0 picks the half
    output la_pkg::byte_t    rdata_o
);

    la_pkg::sample_t mem_q [2**ADDR_W];               // the ring buffer
    la_pkg::sample_t rd_word_q;
    logic            rd_hi_q;

    always_ff @(posedge pll_clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rd_word_q <= mem_q[raddr_i[ADDR_W:1]];        // word select
        rd_hi_q   <= raddr_i[0];
    end

    // even address gives the low byte
    assign rdata_o = rd_hi_q ? rd_word_q[15:8] : rd_word_q[7:0];

endmodule

`default_nettype wire

// File: source/trigger_unit.sv
`timescale 1ns/100ps
`default_nettype none

module trigger_unit #(
    parameter int ADDR_W = 8
) (
    input  wire               pll_clk,
    input  wire               rst_n,
    input  la_pkg::sample_t   probe_i,
    input  la_pkg::sample_t   mask_i,
    input  la_pkg::sample_t   pol_i,
    input  wire               start_i,
    input  wire               running_i,
    input  wire [ADDR_W-1:0]  wr_ptr_i,
    output logic              triggered_o,
    output logic [ADDR_W-1:0] trig_ptr_o
);

    la_pkg::sample_t   prev_q;                        // probe one cycle back
    la_pkg::sample_t   delta;
    la_pkg::sample_t   match;
    logic              event_hit;
    logic              triggered_q;
    logic [ADDR_W-1:0] trig_ptr_q;

    assign delta     = (probe_i ^ prev_q) & mask_i;   // masked pins that moved
    assign match     = ~(probe_i ^ pol_i) & mask_i;   // masked pins at polarity
    assign event_hit = running_i && (|delta) && (|match);

    always_ff @(posedge pll_clk) begin
        prev_q <= probe_i;
    end

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            triggered_q <= 1'b0;
            trig_ptr_q  <= '0;
        end else if (start_i) begin
            triggered_q <= 1'b0;                      // rearm for the new capture
        end else if (event_hit && !triggered_q) begin
            triggered_q <= 1'b1;
            trig_ptr_q  <= wr_ptr_i;                  // first event only
        end
    end

    assign triggered_o = triggered_q || event_hit;    // high already in the event cycle
    assign trig_ptr_o  = trig_ptr_q;

    // once triggered, stays so for the rest of the capture
    a_trig_sticky: assert property (@(posedge pll_clk) disable iff (!rst_n)
        (triggered_o && running_i) |=> (triggered_o || !running_i));

endmodule

`default_nettype wire

// File: source/sample_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sample_ctrl #(
    parameter int ADDR_W = 8                          // 8 up to 15
) (
    input  wire               pll_clk,
    input  wire               rst_n,
    input  wire               start_i,
    input  la_pkg::byte_t     prescale_i,
    input  la_pkg::byte_t     post_i,
    input  wire               triggered_i,
    input  la_pkg::sample_t   probe_i,
    output logic              running_o,
    output logic [ADDR_W-1:0] wr_ptr_o,
    output logic              ram_we_o,
    output la_pkg::sample_t   ram_wdata_o,
    output logic              cap_done_o
);

    localparam int POST_SH = ADDR_W - 8;              // post count unit is 2**(ADDR_W-8)

    logic              running_q;
    la_pkg::byte_t     presc_q;                       // cycles since last sample
    logic [ADDR_W-1:0] wr_ptr_q;
    logic [ADDR_W-1:0] post_q;                        // post-trigger writes left
    logic              cap_done_q;
    logic              presc_hit;
    logic              wr_fire;
    logic              last_wr;

    assign presc_hit = (presc_q == prescale_i);
    assign wr_fire   = presc_hit && (post_q != '0);   // post count is zero outside a capture
    // zero post count ends at once, else the final triggered write ends it
    assign last_wr   = (post_q == '0)
                       || (wr_fire && triggered_i && (post_q == ADDR_W'(1)));

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            running_q  <= 1'b0;
            presc_q    <= '0;
            wr_ptr_q   <= '0;
            post_q     <= '0;
            cap_done_q <= 1'b0;
        end else begin
            cap_done_q <= 1'b0;
            if (start_i) begin
                running_q <= 1'b1;
                presc_q   <= '0;
                wr_ptr_q  <= '0;                      // buffer fills from word 0
                post_q    <= ADDR_W'(post_i) << POST_SH;
            end else if (running_q) begin
                if (presc_hit) begin
                    presc_q <= '0;
                end else begin
                    presc_q <= presc_q + 1'b1;
                end
                if (wr_fire) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;      // wraps around the ring
                    if (triggered_i) begin
                        post_q <= post_q - 1'b1;
                    end
                end
                if (last_wr) begin
                    running_q  <= 1'b0;
                    cap_done_q <= 1'b1;
                end
            end
        end
    end

    assign running_o   = running_q;
    assign wr_ptr_o    = wr_ptr_q;
    assign ram_we_o    = wr_fire;
    assign ram_wdata_o = probe_i;                     // written in the same cycle
    assign cap_done_o  = cap_done_q;

    // no buffer writes outside a capture
    a_we_running: assert property (@(posedge pll_clk) disable iff (!rst_n)
        ram_we_o |-> running_o);

endmodule

`default_nettype wire

// File: source/cmd_seq.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_seq (
    input  wire             pll_clk,
    input  wire             rst_n,
    input  wire             rx_req_i,
    input  la_pkg::byte_t   rx_data_i,
    output logic            rx_ack_o,
    input  wire             cap_done_i,
    input  wire             dump_done_i,
    output logic            start_o,
    output logic            dump_start_o,
    output la_pkg::sample_t mask_o,
    output la_pkg::sample_t pol_o,
    output la_pkg::byte_t   prescale_o,
    output la_pkg::byte_t   post_o
);

    localparam int IDX_W = $clog2(la_pkg::FRAME_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(la_pkg::FRAME_BYTES - 1);

    la_pkg::cmd_state_e state_q;
    logic [IDX_W-1:0]   idx_q;                            // frame byte position
    logic               rx_ack_q;
    logic               dump_start_q;
    la_pkg::byte_t      frame_q [la_pkg::FRAME_BYTES];    // raw frame bytes
    logic               take_byte;

    // new request and no ack out yet
    assign take_byte = (state_q == la_pkg::RECV) && rx_req_i && !rx_ack_q;

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            state_q      <= la_pkg::RECV;
            idx_q        <= '0;
            rx_ack_q     <= 1'b0;
            dump_start_q <= 1'b0;
        end else begin
            dump_start_q <= 1'b0;                         // pulse by default low
            case (state_q)
                la_pkg::RECV: begin
                    if (take_byte) begin
                        rx_ack_q <= 1'b1;                 // phase 2, byte taken
                    end else if (rx_ack_q && !rx_req_i) begin
                        rx_ack_q <= 1'b0;                 // phase 4, release
                        if (idx_q == LAST_IDX) begin
                            idx_q   <= '0;
                            state_q <= la_pkg::ARM;       // frame complete
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                la_pkg::ARM: begin
                    state_q <= la_pkg::CAPTURE;           // start goes out this cycle
                end
                la_pkg::CAPTURE: begin
                    if (cap_done_i) begin
                        dump_start_q <= 1'b1;
                        state_q      <= la_pkg::DUMP;
                    end
                end
                la_pkg::DUMP: begin
                    if (dump_done_i) begin
                        state_q <= la_pkg::RECV;          // ready for the next frame
                    end
                end
                default: state_q <= la_pkg::RECV;
            endcase
        end
    end

    // frame bytes land by position
    always_ff @(posedge pll_clk) begin
        if (take_byte) begin
            frame_q[idx_q] <= rx_data_i;
        end
    end

    assign rx_ack_o     = rx_ack_q;
    assign start_o      = (state_q == la_pkg::ARM);
    assign dump_start_o = dump_start_q;
    assign mask_o       = {frame_q[la_pkg::FRM_MASK_HI], frame_q[la_pkg::FRM_MASK_LO]};
    assign pol_o        = {frame_q[la_pkg::FRM_POL_HI], frame_q[la_pkg::FRM_POL_LO]};
    assign prescale_o   = frame_q[la_pkg::FRM_PRESC];
    assign post_o       = frame_q[la_pkg::FRM_POST];

    // a late ack may only be seen while it is being dropped in RECV
    a_ack_in_recv: assert property (@(posedge pll_clk) disable iff (!rst_n)
        rx_ack_o |-> (state_q == la_pkg::RECV));

endmodule

`default_nettype wire

// File: source/dump_tx.sv
`timescale 1ns/100ps
`default_nettype none

module dump_tx #(
    parameter int ADDR_W = 8
) (
    input  wire               pll_clk,
    input  wire               rst_n,
    input  wire               dump_start_i,
    input  wire [ADDR_W-1:0]  trig_ptr_i,
    output logic [ADDR_W:0]   rd_addr_o,
    input  la_pkg::byte_t     rd_data_i,
    output logic              tx_req_o,
    output la_pkg::byte_t     tx_data_o,
    input  wire               tx_ack_i,
    output logic              dump_done_o
);

    localparam int CNT_W = ADDR_W + 2;
    localparam int RD_W  = ADDR_W + 1;
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(2 ** (ADDR_W + 1) + 1);

    la_pkg::dump_state_e state_q;
    logic [CNT_W-1:0]    cnt_q;                       // byte index, 0 and 1 are the pointer
    logic                rd_wait_q;                   // ram address already presented
    la_pkg::byte_t       data_q;
    logic                done_q;
    logic [15:0]         ptr_word;
    logic                is_ptr;

    assign ptr_word  = 16'(trig_ptr_i);               // zero padded to 16 bits
    assign is_ptr    = (cnt_q < CNT_W'(2));
    assign rd_addr_o = RD_W'(cnt_q - CNT_W'(2));      // buffer bytes follow the pointer

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            state_q   <= la_pkg::IDLE;
            cnt_q     <= '0;
            rd_wait_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                la_pkg::IDLE: begin
                    if (dump_start_i) begin
                        cnt_q     <= '0;
                        rd_wait_q <= 1'b0;
                        state_q   <= la_pkg::LOAD;
                    end
                end
                la_pkg::LOAD: begin
                    if (is_ptr) begin
                        state_q <= la_pkg::REQ;       // pointer bytes need no read
                    end else if (!rd_wait_q) begin
                        rd_wait_q <= 1'b1;            // one cycle ram latency
                    end else begin
                        rd_wait_q <= 1'b0;
                        state_q   <= la_pkg::REQ;
                    end
                end
                la_pkg::REQ: begin
                    if (tx_ack_i) begin
                        state_q <= la_pkg::REL;
                    end
                end
                la_pkg::REL: begin
                    if (!tx_ack_i) begin
                        if (cnt_q == LAST_BYTE) begin
                            done_q  <= 1'b1;
                            state_q <= la_pkg::IDLE;
                        end else begin
                            cnt_q   <= cnt_q + 1'b1;
                            state_q <= la_pkg::LOAD;
                        end
                    end
                end
                default: state_q <= la_pkg::IDLE;
            endcase
        end
    end

    // byte to send, settled in LOAD before req goes up
    always_ff @(posedge pll_clk) begin
        if (state_q == la_pkg::LOAD) begin
            if (cnt_q == CNT_W'(0)) begin
                data_q <= ptr_word[7:0];
            end else if (cnt_q == CNT_W'(1)) begin
                data_q <= ptr_word[15:8];
            end else if (rd_wait_q) begin
                data_q <= rd_data_i;
            end
        end
    end

    assign tx_req_o    = (state_q == la_pkg::REQ);
    assign tx_data_o   = data_q;
    assign dump_done_o = done_q;

    // receiver may sample data any time req is up
    a_data_stable: assert property (@(posedge pll_clk) disable iff (!rst_n)
        tx_req_o |=> (!tx_req_o || $stable(tx_data_o)));

endmodule

`default_nettype wire

// File: source/la_top.sv
`timescale 1ns/100ps
`default_nettype none

module la_top #(
    parameter int ADDR_W = 8                          // buffer depth is 2**ADDR_W words
) (
    input  wire             pll_clk,
    input  wire             rst_n,
    input  la_pkg::sample_t probe_i,                  // pins under test
    input  wire             rx_req_i,
    input  la_pkg::byte_t   rx_data_i,
    output logic            rx_ack_o,
    output logic            tx_req_o,
    output la_pkg::byte_t   tx_data_o,
    input  wire             tx_ack_i
);

    logic            start;                           // one-cycle capture kick
    la_pkg::sample_t mask;
    la_pkg::sample_t pol;
    la_pkg::byte_t   prescale;
    la_pkg::byte_t   post;
    logic            running;
    logic [ADDR_W-1:0] wr_ptr;                        // next word to be written
    logic            ram_we;
    la_pkg::sample_t ram_wdata;
    logic            cap_done;
    logic            triggered;
    logic [ADDR_W-1:0] trig_ptr;
    logic            dump_start;
    logic            dump_done;
    logic [ADDR_W:0] rd_addr;                         // byte address into the buffer
    la_pkg::byte_t   rd_data;

    cmd_seq i_cmd_seq (
        .pll_clk(pll_clk), .rst_n(rst_n),
        .rx_req_i(rx_req_i), .rx_data_i(rx_data_i), .rx_ack_o(rx_ack_o),
        .cap_done_i(cap_done), .dump_done_i(dump_done),
        .start_o(start), .dump_start_o(dump_start),
        .mask_o(mask), .pol_o(pol), .prescale_o(prescale), .post_o(post)
    );

    trigger_unit #(.ADDR_W(ADDR_W)) i_trigger_unit (
        .pll_clk(pll_clk), .rst_n(rst_n),
        .probe_i(probe_i), .mask_i(mask), .pol_i(pol),
        .start_i(start), .running_i(running), .wr_ptr_i(wr_ptr),
        .triggered_o(triggered), .trig_ptr_o(trig_ptr)
    );

    sample_ctrl #(.ADDR_W(ADDR_W)) i_sample_ctrl (
        .pll_clk(pll_clk), .rst_n(rst_n),
        .start_i(start), .prescale_i(prescale), .post_i(post),
        .triggered_i(triggered), .probe_i(probe_i),
        .running_o(running), .wr_ptr_o(wr_ptr),
        .ram_we_o(ram_we), .ram_wdata_o(ram_wdata), .cap_done_o(cap_done)
    );

    sample_ram #(.ADDR_W(ADDR_W)) i_sample_ram (
        .pll_clk(pll_clk),
        .we_i(ram_we), .waddr_i(wr_ptr), .wdata_i(ram_wdata),
        .raddr_i(rd_addr), .rdata_o(rd_data)
    );

    dump_tx #(.ADDR_W(ADDR_W)) i_dump_tx (
        .pll_clk(pll_clk), .rst_n(rst_n),
        .dump_start_i(dump_start), .trig_ptr_i(trig_ptr),
        .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .tx_req_o(tx_req_o), .tx_data_o(tx_data_o), .tx_ack_i(tx_ack_i),
        .dump_done_o(dump_done)
    );

endmodule

`default_nettype wire

// File: sim/la_tb_tasks.svh
    // uniform delay in 0..max_delay cycles
    function automatic int rand_delay(input int max_delay);
        if (max_delay <= 0) begin
            return 0;
        end
        return int'($unsigned($random(seed)) % (max_delay + 1));
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input la_pkg::byte_t got,
                              input la_pkg::byte_t exp);
        if (got !== exp) begin
            byte_errs++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input la_pkg::sample_t got,
                                input la_pkg::sample_t exp);
        if (got !== exp) begin
            sample_errs++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one frame over the four-phase rx channel
    task automatic send_frame(input la_pkg::sample_t mask, input la_pkg::sample_t pol,
                              input la_pkg::byte_t presc, input la_pkg::byte_t post);
        la_pkg::byte_t frame [la_pkg::FRAME_BYTES];
        frame[0] = mask[7:0];                                   // mask, low byte first
        frame[1] = mask[15:8];
        frame[2] = pol[7:0];
        frame[3] = pol[15:8];
        frame[4] = presc;
        frame[5] = post;
        for (int i = 0; i < la_pkg::FRAME_BYTES; i++) begin
            @(negedge pll_clk);
            rx_data_i = frame[i];
            rx_req_i  = 1'b1;
            while (rx_ack_o !== 1'b1) begin
                @(negedge pll_clk);
            end
            rx_req_i = 1'b0;
            while (rx_ack_o !== 1'b0) begin
                @(negedge pll_clk);
            end
        end
    endtask

    // collect the whole dump, random stalls on both ack edges
    task automatic recv_dump(input int max_delay);
        int delay;
        for (int n = 0; n < DUMP_BYTES; n++) begin
            while (tx_req_o !== 1'b1) begin
                @(negedge pll_clk);
            end
            dump_bytes[n] = tx_data_o;
            delay = rand_delay(max_delay);
            repeat (delay) begin
                @(negedge pll_clk);
                check_byte("tx_data_o", tx_data_o, dump_bytes[n]);  // held while req up
            end
            tx_ack_i = 1'b1;
            @(negedge pll_clk);
            while (tx_req_o !== 1'b0) begin
                @(negedge pll_clk);
            end
            delay = rand_delay(max_delay);
            repeat (delay) @(negedge pll_clk);
            tx_ack_i = 1'b0;
            @(negedge pll_clk);
        end
    endtask

    // anything past the last byte is a length error
    task automatic expect_no_extra_bytes(input int cycles);
        repeat (cycles) begin
            @(negedge pll_clk);
            check_flag("tx_req_o", tx_req_o, 1'b0);
        end
    endtask

    // A long enough to fill the ring, optional pre value, then B held
    task automatic drive_probe_sequence(input la_pkg::sample_t mask, input la_pkg::sample_t pol,
                                        input la_pkg::byte_t presc, input la_pkg::byte_t post,
                                        input la_pkg::sample_t a_val,
                                        input la_pkg::sample_t pre_val, input int pre_cycles,
                                        input la_pkg::sample_t b_val);
        probe_i = a_val;
        send_frame(mask, pol, presc, post);
        repeat (DEPTH * (int'(presc) + 1) + 8) @(negedge pll_clk);
        if (pre_cycles > 0) begin
            probe_i = pre_val;                                  // exact word count needs presc 0
            repeat (pre_cycles) @(negedge pll_clk);
        end
        probe_i = b_val;
    endtask

    // expected ring rebuilt around the received pointer
    task automatic verify_buffer(input la_pkg::sample_t a_val, input la_pkg::sample_t pre_val,
                                 input int pre_len, input la_pkg::sample_t b_val,
                                 input la_pkg::byte_t post);
        la_pkg::sample_t ptr;
        la_pkg::sample_t got;
        la_pkg::sample_t exp_word [DEPTH];
        int              trig;
        int              post_words;
        ptr = {dump_bytes[1], dump_bytes[0]};                   // low byte came first
        check_sample("trig_ptr upper bits", ptr & ~la_pkg::sample_t'(DEPTH - 1), '0);
        trig       = int'(ptr) % DEPTH;
        post_words = int'(post) << (ADDR_W - 8);                // count unit scales with depth
        for (int i = 0; i < DEPTH; i++) begin
            exp_word[i] = a_val;
        end
        for (int k = 1; k <= pre_len; k++) begin
            exp_word[(trig - k + DEPTH) % DEPTH] = pre_val;     // just before the trigger
        end
        for (int k = 0; k < post_words; k++) begin
            exp_word[(trig + k) % DEPTH] = b_val;
        end
        for (int i = 0; i < DEPTH; i++) begin
            got = {dump_bytes[2 * i + 3], dump_bytes[2 * i + 2]};
            check_sample($sformatf("buffer word %0d", i), got, exp_word[i]);
        end
    endtask

    task automatic run_capture(input la_pkg::sample_t mask, input la_pkg::sample_t pol,
                               input la_pkg::byte_t presc, input la_pkg::byte_t post,
                               input la_pkg::sample_t a_val, input la_pkg::sample_t pre_val,
                               input int pre_cycles, input la_pkg::sample_t b_val,
                               input int max_delay);
        drive_probe_sequence(mask, pol, presc, post, a_val, pre_val, pre_cycles, b_val);
        recv_dump(max_delay);
        expect_no_extra_bytes(16);
        verify_buffer(a_val, pre_val, pre_cycles, b_val, post);
    endtask

    // nothing moves on either channel without a frame
    task automatic idle_after_reset();
        repeat (32) begin
            @(negedge pll_clk);
            check_flag("rx_ack_o", rx_ack_o, 1'b0);
            check_flag("tx_req_o", tx_req_o, 1'b0);
        end
    endtask

    task automatic basic_trigger();
        run_capture(16'h0001, 16'h0001, 8'd2, 8'd64,
                    16'h5a5a, 16'h5a5a, 0, 16'hc3a5, 0);        // bit 0 rises
    endtask

    // bit 0 falls to C first, which must not trigger
    task automatic polarity_trigger();
        run_capture(16'h0001, 16'h0001, 8'd0, 8'd100,
                    16'h1235, 16'h2468, 20, 16'h9ab1, 2);
    endtask

    // bit 4 moves to its pol value but is unmasked
    task automatic mask_trigger();
        run_capture(16'h0001, 16'h0011, 8'd0, 8'd40,
                    16'h0f00, 16'h0f10, 30, 16'h0f11, 1);
    endtask

    task automatic back_pressure();
        drive_probe_sequence(16'h8000, 16'h0000, 8'd1, 8'd200,
                             16'h8123, 16'h8123, 0, 16'h0456);  // bit 15 falls
        dump_busy = 1'b1;
        fork
            begin
                recv_dump(MAX_DELAY);
                dump_busy = 1'b0;
            end
            begin
                wait (tx_req_o === 1'b1);
                @(negedge pll_clk);
                rx_data_i = 8'h00;                              // first byte of the next frame
                rx_req_i  = 1'b1;
                while (dump_busy) begin
                    if (rx_ack_o !== 1'b0) begin
                        hs_errs++;
                        $display("rx_ack_o answered a frame byte while the dump was running");
                    end
                    @(negedge pll_clk);
                end
            end
        join
        expect_no_extra_bytes(16);
        verify_buffer(16'h8123, 16'h8123, 0, 16'h0456, 8'd200);
        // pending byte 0 is taken now, rest of the frame follows
        run_capture(16'h0300, 16'h0200, 8'd3, 8'd255,
                    16'h0055, 16'h0055, 0, 16'h0255, 3);
    endtask

// File: sim/la_tb.sv
`timescale 1ns/100ps
`default_nettype none

module la_tb;

    localparam int ADDR_W         = 8;
    localparam int DEPTH          = 2 ** ADDR_W;                // buffer words
    localparam int DUMP_BYTES     = 2 + 2 ** (ADDR_W + 1);      // pointer, then every buffer byte
    localparam int MAX_PRESC      = 3;                          // slowest prescale in the tests
    localparam int MAX_DELAY      = 5;                          // longest random ack delay
    localparam int N_CAPTURES     = 5;
    localparam int FILL_CYCLES    = 2 * DEPTH * (MAX_PRESC + 1) + 64;  // prefill plus post window
    localparam int HS_CYCLES      = 2 * MAX_DELAY + 8;          // worst four-phase round per byte
    localparam int TIMEOUT_CYCLES = N_CAPTURES * (FILL_CYCLES + DUMP_BYTES * HS_CYCLES) + 2000;

    logic            pll_clk;
    logic            rst_n;
    la_pkg::sample_t probe_i;
    logic            rx_req_i;
    la_pkg::byte_t   rx_data_i;
    logic            rx_ack_o;
    logic            tx_req_o;
    la_pkg::byte_t   tx_data_o;
    logic            tx_ack_i;

    la_pkg::byte_t   dump_bytes [DUMP_BYTES];                   // last dump as received
    logic            dump_busy;                                 // dump still being received
    int              seed;
    int              cycle_cnt;
    int              byte_errs   = 0;
    int              sample_errs = 0;
    int              flag_errs   = 0;
    int              hs_errs     = 0;                           // handshake order failures

    la_top #(.ADDR_W(ADDR_W)) i_dut (
        .pll_clk(pll_clk), .rst_n(rst_n), .probe_i(probe_i),
        .rx_req_i(rx_req_i), .rx_data_i(rx_data_i), .rx_ack_o(rx_ack_o),
        .tx_req_o(tx_req_o), .tx_data_o(tx_data_o), .tx_ack_i(tx_ack_i)
    );

    initial begin
        pll_clk = 1'b0;
        forever #10 pll_clk = ~pll_clk;                         // 20 ns period
    end

    task automatic print_counts();
        $display("byte errors %0d, sample errors %0d, flag errors %0d, handshake errors %0d",
                 byte_errs, sample_errs, flag_errs, hs_errs);
    endtask

    `include "la_tb_tasks.svh"

    // hard stop if the DUT stops answering
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge pll_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
        print_counts();
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        probe_i   = '0;
        rx_req_i  = 1'b0;
        rx_data_i = '0;
        tx_ack_i  = 1'b0;
        dump_busy = 1'b0;
        seed      = 32'ha7ea4c56;
        repeat (8) @(negedge pll_clk);                          // 8 cycles in reset
        rst_n = 1'b1;
        idle_after_reset();
        basic_trigger();
        polarity_trigger();
        mask_trigger();
        back_pressure();
        print_counts();
        if (byte_errs + sample_errs + flag_errs + hs_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+sim
source/la_pkg.sv
source/sample_ram.sv
source/trigger_unit.sv
source/sample_ctrl.sv
source/cmd_seq.sv
source/dump_tx.sv
source/la_top.sv
sim/la_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the logic analyser testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module la_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vla_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
